// File: list.f
+incdir+src
src/mem_types_pkg.sv
src/rt_ctrl_pkg.sv
src/bank_ram.sv
src/bank_array.sv
src/port_arbiter.sv
src/req_port.sv
src/rt_mem_top.sv
dv/tb_rt_mem.sv

// File: Makefile
TOP = tb_rt_mem

.PHONY: sim clean

# A $fatal in the testbench makes the binary exit nonzero
sim:
	verilator --binary --timing -j 0 --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: dv/tb_rt_mem.sv
`include "rt_mem_macros.svh"

module tb_rt_mem;

    localparam int NP    = `RT_NUM_PORT;
    localparam int NT    = `RT_NUM_THREAD;
    localparam int LIMIT = 200;

    logic                      clk;
    logic                      rst_n;
    logic                      req      [NP];
    logic                      we       [NP];
    logic                      mode     [NP];
    mem_types_pkg::byte_addr_t addr     [NP];
    mem_types_pkg::line_t      data_in  [NP];
    logic                      busy     [NP];
    logic                      rd_rdy   [NP];
    mem_types_pkg::line_t      data_out [NP];

    // Reference words, one region per thread
    mem_types_pkg::word_t ref_mem [NT][1024];

    rt_mem_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .we       (we),
        .mode     (mode),
        .addr     (addr),
        .data_in  (data_in),
        .busy     (busy),
        .rd_rdy   (rd_rdy),
        .data_out (data_out)
    );

    always #10 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_line(input string name, input mem_types_pkg::line_t got,
                              input mem_types_pkg::line_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    function automatic mem_types_pkg::byte_addr_t make_addr(input int t, input int w);
        mem_types_pkg::byte_addr_t a;
        a        = '0;
        a[14:12] = 3'(t);
        a[11:2]  = 10'(w);
        return a;
    endfunction

    function automatic mem_types_pkg::line_t rand_line();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    // Line words follow the first word and wrap inside the region
    function automatic mem_types_pkg::line_t model_line(input mem_types_pkg::byte_addr_t a);
        mem_types_pkg::line_t l;
        logic [9:0]           w;
        for (int k = 0; k < 4; k++) begin
            w             = a[11:2] + 10'(k);
            l[32*k +: 32] = ref_mem[a[14:12]][w];
        end
        return l;
    endfunction

    function automatic void model_write(input mem_types_pkg::byte_addr_t a,
                                        input rt_ctrl_pkg::access_e kind,
                                        input mem_types_pkg::line_t d);
        logic [9:0] w;
        for (int k = 0; k < 4; k++) begin
            w = a[11:2] + 10'(k);
            if (kind == rt_ctrl_pkg::ACC_LINE_WRITE ||
                (kind == rt_ctrl_pkg::ACC_WORD_WRITE && k == 0)) begin
                ref_mem[a[14:12]][w] = d[32*k +: 32];
            end
        end
    endfunction

    task automatic wait_idle(input int p);
        int n;
        n = 0;
        while (busy[p] && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (busy[p]) begin
            stop_run($sformatf("Timeout: port %0d stayed busy", p));
        end
    endtask

    task automatic wait_rdy(input int p);
        int n;
        n = 0;
        while (!rd_rdy[p] && n < LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!rd_rdy[p]) begin
            stop_run($sformatf("Timeout: no read data on port %0d", p));
        end
    endtask

    // Sets one port's request inputs, strobe stays up until dropped
    task automatic drive(input int p, input rt_ctrl_pkg::access_e kind,
                         input mem_types_pkg::byte_addr_t a, input mem_types_pkg::line_t d);
        req[p]     = 1'b1;
        we[p]      = (kind != rt_ctrl_pkg::ACC_READ);
        mode[p]    = (kind == rt_ctrl_pkg::ACC_LINE_WRITE);
        addr[p]    = a;
        data_in[p] = d;
        model_write(a, kind, d);
    endtask

    task automatic issue(input int p, input rt_ctrl_pkg::access_e kind,
                         input mem_types_pkg::byte_addr_t a, input mem_types_pkg::line_t d);
        wait_idle(p);
        drive(p, kind, a, d);
        @(negedge clk);
        req[p] = 1'b0;
    endtask

    task automatic read_check(input int p, input mem_types_pkg::byte_addr_t a);
        mem_types_pkg::line_t exp;
        exp = model_line(a);
        issue(p, rt_ctrl_pkg::ACC_READ, a, '0);
        wait_rdy(p);
        check_line($sformatf("data_out[%0d]", p), data_out[p], exp);
    endtask

    task automatic reset_values();
        for (int p = 0; p < NP; p++) begin
            check_bit($sformatf("busy[%0d]", p), busy[p], 1'b0);
            check_bit($sformatf("rd_rdy[%0d]", p), rd_rdy[p], 1'b0);
            check_line($sformatf("data_out[%0d]", p), data_out[p], '0);
        end
    endtask

    // Whole memory gets filled so later reads never see unwritten words
    task automatic fill_and_patch();
        mem_types_pkg::byte_addr_t a;
        for (int t = 0; t < NT; t++) begin
            for (int r = 0; r < 256; r++) begin
                issue(r % NP, rt_ctrl_pkg::ACC_LINE_WRITE, make_addr(t, 4 * r), rand_line());
            end
        end
        for (int p = 0; p < NP; p++) begin
            wait_idle(p);
        end
        a = make_addr(2, 40);
        issue(1, rt_ctrl_pkg::ACC_WORD_WRITE, a, {96'h0, 32'hc0de_0028});
        wait_idle(1);
        read_check(2, a);
    endtask

    task automatic wrapped_line();
        issue(0, rt_ctrl_pkg::ACC_LINE_WRITE, make_addr(4, 1021), rand_line());
        wait_idle(0);
        read_check(3, make_addr(4, 1022));
        read_check(1, make_addr(4, 1021));
    endtask

    // Read data is due exactly six cycles after the strobe
    task automatic parallel_reads();
        mem_types_pkg::line_t exp [NP];
        for (int p = 0; p < NP; p++) begin
            addr[p] = make_addr(2 * p + 1, $urandom_range(1023, 0));
            exp[p]  = model_line(addr[p]);
            drive(p, rt_ctrl_pkg::ACC_READ, addr[p], '0);
        end
        for (int c = 1; c <= 7; c++) begin
            @(negedge clk);
            for (int p = 0; p < NP; p++) begin
                req[p] = 1'b0;
                if (c == 1) begin
                    check_bit($sformatf("busy[%0d]", p), busy[p], 1'b1);
                end
                check_bit($sformatf("rd_rdy[%0d]", p), rd_rdy[p], c == 6);
                if (c == 6) begin
                    check_line($sformatf("data_out[%0d]", p), data_out[p], exp[p]);
                end
            end
        end
    endtask

    task automatic contended_writes();
        for (int p = 0; p < NP; p++) begin
            drive(p, rt_ctrl_pkg::ACC_LINE_WRITE, make_addr(6, 200 + 5 * p), rand_line());
        end
        @(negedge clk);
        for (int p = 0; p < NP; p++) begin
            req[p] = 1'b0;
        end
        for (int p = 0; p < NP; p++) begin
            wait_idle(p);
        end
        for (int p = 0; p < NP; p++) begin
            read_check((p + 1) % NP, make_addr(6, 200 + 5 * p));
        end
    endtask

    task automatic random_traffic();
        mem_types_pkg::byte_addr_t a;
        rt_ctrl_pkg::access_e      kind;
        int                        p;
        int                        k;
        for (int n = 0; n < 60; n++) begin
            p = $urandom_range(NP - 1, 0);
            k = $urandom_range(2, 0);
            // Upper and byte bits random, the DUT ignores them
            a        = $urandom();
            a[14:12] = 3'($urandom_range(NT - 1, 0));
            a[11:2]  = 10'($urandom_range(1023, 0));
            kind     = (k == 0) ? rt_ctrl_pkg::ACC_READ :
                       (k == 1) ? rt_ctrl_pkg::ACC_WORD_WRITE : rt_ctrl_pkg::ACC_LINE_WRITE;
            if (kind == rt_ctrl_pkg::ACC_READ) begin
                read_check(p, a);
            end else begin
                issue(p, kind, a, rand_line());
                wait_idle(p);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hf8e5));
        clk   = 1'b0;
        rst_n = 1'b0;
        for (int p = 0; p < NP; p++) begin
            req[p]     = 1'b0;
            we[p]      = 1'b0;
            mode[p]    = 1'b0;
            addr[p]    = '0;
            data_in[p] = '0;
        end
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        reset_values();
        fill_and_patch();
        wrapped_line();
        parallel_reads();
        contended_writes();
        random_traffic();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: src/rt_mem_top.sv
`include "rt_mem_macros.svh"

module rt_mem_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req      [`RT_NUM_PORT],
    input  logic                      we       [`RT_NUM_PORT],
    input  logic                      mode     [`RT_NUM_PORT],
    input  mem_types_pkg::byte_addr_t addr     [`RT_NUM_PORT],
    input  mem_types_pkg::line_t      data_in  [`RT_NUM_PORT],
    output logic                      busy     [`RT_NUM_PORT],
    output logic                      rd_rdy   [`RT_NUM_PORT],
    output mem_types_pkg::line_t      data_out [`RT_NUM_PORT]
);

    logic                      pend        [`RT_NUM_PORT];
    mem_types_pkg::thread_id_t pend_thread [`RT_NUM_PORT];
    logic                      grant       [`RT_NUM_PORT];
    rt_ctrl_pkg::access_e      iss_kind    [`RT_NUM_PORT];
    mem_types_pkg::byte_addr_t iss_addr    [`RT_NUM_PORT];
    mem_types_pkg::line_t      iss_data    [`RT_NUM_PORT];

    for (genvar i = 0; i < `RT_NUM_PORT; i++) begin : g_port
        req_port u_port (
            .clk         (clk),
            .rst_n       (rst_n),
            .req         (req[i]),
            .we          (we[i]),
            .mode        (mode[i]),
            .addr        (addr[i]),
            .data_in     (data_in[i]),
            .grant       (grant[i]),
            .busy        (busy[i]),
            .pend        (pend[i]),
            .pend_thread (pend_thread[i]),
            .iss_kind    (iss_kind[i]),
            .iss_addr    (iss_addr[i]),
            .iss_data    (iss_data[i])
        );
    end

    port_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .pend        (pend),
        .pend_thread (pend_thread),
        .grant       (grant)
    );

    // A grant is the issue strobe into the memory pipeline
    bank_array u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .iss_valid (grant),
        .iss_kind  (iss_kind),
        .iss_addr  (iss_addr),
        .iss_data  (iss_data),
        .rd_rdy    (rd_rdy),
        .data_out  (data_out)
    );

endmodule

// File: src/req_port.sv
module req_port (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req,
    input  logic                      we,
    input  logic                      mode,
    input  mem_types_pkg::byte_addr_t addr,
    input  mem_types_pkg::line_t      data_in,
    input  logic                      grant,
    output logic                      busy,
    output logic                      pend,
    output mem_types_pkg::thread_id_t pend_thread,
    output rt_ctrl_pkg::access_e      iss_kind,
    output mem_types_pkg::byte_addr_t iss_addr,
    output mem_types_pkg::line_t      iss_data
);

    localparam int THR_LSB = 2 + $bits(mem_types_pkg::word_idx_t);

    rt_ctrl_pkg::port_state_e state;
    logic                     accept;

    // Strobes while a request is held are dropped
    assign accept = (state == rt_ctrl_pkg::IDLE) && req;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= rt_ctrl_pkg::IDLE;
        end else begin
            case (state)
                rt_ctrl_pkg::IDLE: begin
                    if (req) begin
                        state <= rt_ctrl_pkg::PENDING;
                    end
                end
                rt_ctrl_pkg::PENDING: begin
                    if (grant) begin
                        state <= rt_ctrl_pkg::IDLE;
                    end
                end
                default: state <= rt_ctrl_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_addr <= addr;
            iss_data <= data_in;
            if (!we) begin
                iss_kind <= rt_ctrl_pkg::ACC_READ;
            end else if (mode) begin
                iss_kind <= rt_ctrl_pkg::ACC_LINE_WRITE;
            end else begin
                iss_kind <= rt_ctrl_pkg::ACC_WORD_WRITE;
            end
        end
    end

    assign pend        = (state == rt_ctrl_pkg::PENDING);
    assign busy        = pend;
    assign pend_thread = iss_addr[THR_LSB +: $bits(mem_types_pkg::thread_id_t)];

endmodule

// File: src/port_arbiter.sv
`include "rt_mem_macros.svh"

module port_arbiter (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      pend        [`RT_NUM_PORT],
    input  mem_types_pkg::thread_id_t pend_thread [`RT_NUM_PORT],
    output logic                      grant       [`RT_NUM_PORT]
);

    localparam int NP = `RT_NUM_PORT;
    localparam int PW = $clog2(NP);

    // Port count is a power of two, so the pointer wraps by itself
    logic [PW-1:0]             ptr;
    logic [PW-1:0]             idx;
    logic [`RT_NUM_THREAD-1:0] taken;
    logic                      conflict;

    // Ports walked from the pointer and the first claim on a thread wins
    always_comb begin
        taken    = '0;
        conflict = 1'b0;
        idx      = '0;
        for (int i = 0; i < NP; i++) begin
            grant[i] = 1'b0;
        end
        for (int k = 0; k < NP; k++) begin
            idx = ptr + PW'(k);
            if (pend[idx]) begin
                if (taken[pend_thread[idx]]) begin
                    conflict = 1'b1;
                end else begin
                    grant[idx]               = 1'b1;
                    taken[pend_thread[idx]]  = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (conflict) begin
            ptr <= ptr + PW'(1);
        end
    end

endmodule

// File: src/bank_array.sv
`include "rt_mem_macros.svh"

module bank_array (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      iss_valid [`RT_NUM_PORT],
    input  rt_ctrl_pkg::access_e      iss_kind  [`RT_NUM_PORT],
    input  mem_types_pkg::byte_addr_t iss_addr  [`RT_NUM_PORT],
    input  mem_types_pkg::line_t      iss_data  [`RT_NUM_PORT],
    output logic                      rd_rdy    [`RT_NUM_PORT],
    output mem_types_pkg::line_t      data_out  [`RT_NUM_PORT]
);

    localparam int NP = `RT_NUM_PORT;
    localparam int NT = `RT_NUM_THREAD;
    localparam int NB = `RT_NUM_BANK;
    localparam int PW = $clog2(NP);
    localparam int WW = $bits(mem_types_pkg::word_t);
    localparam int THR_LSB = 2 + $bits(mem_types_pkg::word_idx_t);

    // Stage 0 registers, per port and bank
    logic                      val_0  [NP];
    logic                      wen_0  [NP][NB];
    mem_types_pkg::row_addr_t  row_0  [NP][NB];
    mem_types_pkg::word_t      wdat_0 [NP][NB];
    mem_types_pkg::thread_id_t thr_0  [NP];
    mem_types_pkg::thread_id_t thr_1  [NP];
    mem_types_pkg::thread_id_t thr_2  [NP];

    // First addressed bank, needed again for the read rotation
    mem_types_pkg::bank_id_t   base_0 [NP];
    mem_types_pkg::bank_id_t   base_1 [NP];
    mem_types_pkg::bank_id_t   base_2 [NP];
    mem_types_pkg::bank_id_t   base_3 [NP];

    logic                      rd_0 [NP];
    logic                      rd_1 [NP];
    logic                      rd_2 [NP];
    logic                      rd_3 [NP];
    mem_types_pkg::line_t      line_3 [NP];

    // Stage 1 registers per thread and bank, feeding the RAMs
    logic                      we_1   [NT][NB];
    mem_types_pkg::row_addr_t  row_1  [NT][NB];
    mem_types_pkg::word_t      wdat_1 [NT][NB];
    mem_types_pkg::word_t      q_2    [NT][NB];
    mem_types_pkg::line_t      q_line [NT];

    for (genvar p = 0; p < NP; p++) begin : g_port
        mem_types_pkg::word_idx_t widx;
        mem_types_pkg::bank_id_t  base;
        mem_types_pkg::line_t     rot;

        assign widx = iss_addr[p][THR_LSB-1:2];
        assign base = widx[$bits(mem_types_pkg::bank_id_t)-1:0];

        for (genvar j = 0; j < NB; j++) begin : g_bank
            // Offset within the line of the word that lands in bank j
            mem_types_pkg::bank_id_t  k;
            mem_types_pkg::word_idx_t idx;

            assign k   = mem_types_pkg::bank_id_t'(j) - base;
            assign idx = widx + mem_types_pkg::word_idx_t'(k);

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    wen_0[p][j] <= 1'b0;
                end else begin
                    wen_0[p][j] <= iss_valid[p] &&
                                   (iss_kind[p] == rt_ctrl_pkg::ACC_LINE_WRITE ||
                                    (iss_kind[p] == rt_ctrl_pkg::ACC_WORD_WRITE && k == '0));
                end
            end

            always_ff @(posedge clk) begin
                row_0[p][j]  <= idx[$bits(idx)-1 -: $bits(mem_types_pkg::row_addr_t)];
                wdat_0[p][j] <= iss_data[p][WW*k +: WW];
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                val_0[p]  <= 1'b0;
                rd_0[p]   <= 1'b0;
                rd_1[p]   <= 1'b0;
                rd_2[p]   <= 1'b0;
                rd_3[p]   <= 1'b0;
                rd_rdy[p] <= 1'b0;
            end else begin
                val_0[p]  <= iss_valid[p];
                rd_0[p]   <= iss_valid[p] && iss_kind[p] == rt_ctrl_pkg::ACC_READ;
                rd_1[p]   <= rd_0[p];
                rd_2[p]   <= rd_1[p];
                rd_3[p]   <= rd_2[p];
                rd_rdy[p] <= rd_3[p];
            end
        end

        always_ff @(posedge clk) begin
            thr_0[p]  <= iss_addr[p][THR_LSB +: $bits(mem_types_pkg::thread_id_t)];
            thr_1[p]  <= thr_0[p];
            thr_2[p]  <= thr_1[p];
            base_0[p] <= base;
            base_1[p] <= base_0[p];
            base_2[p] <= base_1[p];
            base_3[p] <= base_2[p];
            // Stage 3, pick the addressed thread's line
            line_3[p] <= q_line[thr_2[p]];
        end

        // Put the first addressed word back at word 0
        always_comb begin
            mem_types_pkg::bank_id_t src;
            src = '0;
            for (int w = 0; w < NB; w++) begin
                src = base_3[p] + mem_types_pkg::bank_id_t'(w);
                rot[WW*w +: WW] = line_3[p][WW*src +: WW];
            end
        end

        // Stage 4, holds the last read line between reads
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                data_out[p] <= '0;
            end else if (rd_3[p]) begin
                data_out[p] <= rot;
            end
        end
    end

    for (genvar t = 0; t < NT; t++) begin : g_thread
        logic          hit;
        logic [PW-1:0] sel;

        // At most one valid port per thread, the arbiter sees to that
        always_comb begin
            hit = 1'b0;
            sel = '0;
            for (int p = 0; p < NP; p++) begin
                if (val_0[p] && thr_0[p] == mem_types_pkg::thread_id_t'(t)) begin
                    hit = 1'b1;
                    sel = PW'(p);
                end
            end
        end

        for (genvar j = 0; j < NB; j++) begin : g_bank
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    we_1[t][j] <= 1'b0;
                end else begin
                    we_1[t][j] <= hit && wen_0[sel][j];
                end
            end

            always_ff @(posedge clk) begin
                row_1[t][j]  <= row_0[sel][j];
                wdat_1[t][j] <= wdat_0[sel][j];
            end

            bank_ram u_ram (
                .clk  (clk),
                .we   (we_1[t][j]),
                .addr (row_1[t][j]),
                .data (wdat_1[t][j]),
                .q    (q_2[t][j])
            );
        end

        always_comb begin
            for (int j = 0; j < NB; j++) begin
                q_line[t][WW*j +: WW] = q_2[t][j];
            end
        end
    end

endmodule

// File: src/bank_ram.sv
module bank_ram (
    input  logic                     clk,
    input  logic                     we,
    input  mem_types_pkg::row_addr_t addr,
    input  mem_types_pkg::word_t     data,
    output mem_types_pkg::word_t     q
);

    mem_types_pkg::word_t mem [1 << $bits(mem_types_pkg::row_addr_t)];

    // Read-before-write, q shows the old word on a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= data;
        end
        q <= mem[addr];
    end

endmodule

// File: src/rt_ctrl_pkg.sv
package rt_ctrl_pkg;

    typedef enum logic {
        IDLE,
        PENDING
    } port_state_e;

    typedef enum logic [1:0] {
        ACC_READ       = 2'd0,
        ACC_WORD_WRITE = 2'd1,
        ACC_LINE_WRITE = 2'd2
    } access_e;

endpackage

// File: src/mem_types_pkg.sv
`include "rt_mem_macros.svh"

package mem_types_pkg;

    // Byte address, thread id sits just above the word index
    typedef logic [31:0] byte_addr_t;

    typedef logic [31:0] word_t;

    // Word k of a line at bits 32k+31:32k
    typedef logic [`RT_NUM_BANK*32-1:0] line_t;

    typedef logic [`RT_THREAD_W-1:0] thread_id_t;

    typedef logic [$clog2(`RT_NUM_BANK)-1:0] bank_id_t;

    typedef logic [`RT_ROW_W-1:0] row_addr_t;

    // Row in the upper bits, bank in the lower
    typedef logic [`RT_ROW_W+$clog2(`RT_NUM_BANK)-1:0] word_idx_t;

endpackage

// File: src/rt_mem_macros.svh
`ifndef RT_MEM_MACROS_SVH
`define RT_MEM_MACROS_SVH

// Core request ports
`define RT_NUM_PORT 4

// Thread regions, one per thread id
`define RT_NUM_THREAD 8
`define RT_THREAD_W 3

// Word-interleaved banks inside one region
`define RT_NUM_BANK 4

// Row address width of a single bank
`define RT_ROW_W 8

`endif
